//--- logic/mdu_pkg.sv
/*
 * Multiply/divide unit shared definitions.
 * Data widths, opcode encoding, register map, control and status
 * bit positions, and the multiplier unroll factor.
 */

package mdu_pkg;

    // --------------------------------------------------
    // Data widths
    // --------------------------------------------------
    localparam int xlen = 64;
    localparam int wlen = 32;      // Width of the W forms

    // --------------------------------------------------
    // Iteration control
    // --------------------------------------------------
    localparam int mul_unroll = 4;                    // Must divide 32
    localparam int mul_steps  = xlen / mul_unroll;    // Full-width cycles
    localparam int mul_ctr_w  = $clog2(mul_steps + 1);
    localparam int div_ctr_w  = $clog2(xlen + 1);

    // --------------------------------------------------
    // Opcode encoding
    // --------------------------------------------------
    localparam int ctrl_op_w = 4;

    // Bit 2 set selects the divider
    typedef enum logic [ctrl_op_w-1:0] {
        op_mul    = 4'd0,
        op_mulh   = 4'd1,
        op_mulhsu = 4'd2,
        op_mulhu  = 4'd3,
        op_div    = 4'd4,
        op_divu   = 4'd5,
        op_rem    = 4'd6,
        op_remu   = 4'd7
    } mdu_op_e;

    // --------------------------------------------------
    // Register map (64-bit word addresses)
    // --------------------------------------------------
    localparam logic [2:0] addr_rs1    = 3'd0;
    localparam logic [2:0] addr_rs2    = 3'd1;
    localparam logic [2:0] addr_ctrl   = 3'd2;
    localparam logic [2:0] addr_result = 3'd3;
    localparam logic [2:0] addr_status = 3'd4;

    // Control word fields
    localparam int ctrl_op_lsb    = 0;    // ctrl_op_w bits
    localparam int ctrl_word_bit  = 4;    // W form
    localparam int ctrl_abort_bit = 8;    // Abort, not stored

    // Status word fields
    localparam int stat_busy_bit = 0;
    localparam int stat_done_bit = 1;

endpackage

//--- logic/mdu_multiplier.sv
/*
 * Iterative shift-add multiplier.
 * Retires mul_unroll multiplier bits per cycle into a 128-bit
 * accumulator; returns low or high product half, or a W result.
 */

`timescale 1ns/1ps

module mdu_multiplier (
    input  logic                     g_clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     abort,
    input  mdu_pkg::mdu_op_e         op,
    input  logic                     op_word,
    input  logic [mdu_pkg::xlen-1:0] rs1,
    input  logic [mdu_pkg::xlen-1:0] rs2,
    output logic                     done,
    output logic [mdu_pkg::xlen-1:0] result
);

    import mdu_pkg::*;

    logic [2*xlen-1:0]  acc;        // {high, low} partial product
    logic [2*xlen-1:0]  acc_nxt;
    logic [xlen-1:0]    mcand;      // Multiplicand, extended for W forms
    logic [xlen-1:0]    mplier;     // Shifts right by mul_unroll each step
    logic [mul_ctr_w-1:0] ctr;      // Steps left
    logic               run;
    logic               a_signed;
    logic               b_signed;
    logic [xlen-1:0]    a_in;
    logic [xlen-1:0]    b_in;

    assign a_signed = (op == op_mulh) || (op == op_mulhsu);
    assign b_signed = (op == op_mulh);

    // W forms take the low word, extended per operand signedness
    assign a_in = op_word ? {{wlen{a_signed & rs1[wlen-1]}}, rs1[wlen-1:0]} : rs1;
    assign b_in = op_word ? {{wlen{b_signed & rs2[wlen-1]}}, rs2[wlen-1:0]} : rs2;

    // --------------------------------------------------
    // One step: mul_unroll partial products
    // --------------------------------------------------
    always_comb begin
        logic [xlen:0] hi_ext;
        logic [xlen:0] add_ext;
        logic [xlen:0] sum;
        logic          sub;

        acc_nxt = acc;
        for (int i = 0; i < mul_unroll; i++) begin
            // Top bit of a signed multiplier carries negative weight
            sub     = b_signed && (ctr == 1) && (i == mul_unroll - 1) && mplier[i];
            hi_ext  = {a_signed & acc_nxt[2*xlen-1], acc_nxt[2*xlen-1:xlen]};
            add_ext = mplier[i] ? {a_signed & mcand[xlen-1], mcand} : '0;
            sum     = sub ? hi_ext - add_ext : hi_ext + add_ext;
            acc_nxt = {sum, acc_nxt[xlen-1:1]};
        end
    end

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (rst || abort) begin
            run  <= 1'b0;
            done <= 1'b0;
            ctr  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                run <= 1'b1;
                ctr <= op_word ? mul_ctr_w'(wlen / mul_unroll) : mul_ctr_w'(mul_steps);
            end else if (run) begin
                if (ctr == 0) begin
                    run  <= 1'b0;
                    done <= 1'b1;      // Extra cycle after the last step
                end else begin
                    ctr <= ctr - 1'b1;
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge g_clk) begin
        if (start) begin
            acc    <= '0;
            mcand  <= a_in;
            mplier <= b_in;
        end else if (run && ctr != 0) begin
            acc    <= acc_nxt;
            mplier <= mplier >> mul_unroll;
        end
    end

    // W result sits in acc[63:32] after 32 shifts
    assign result = op_word        ? {{wlen{acc[xlen-1]}}, acc[xlen-1:wlen]} :
                    (op == op_mul) ? acc[xlen-1:0] :
                                     acc[2*xlen-1:xlen];

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    a_run_done_excl: assert property (@(posedge g_clk) disable iff (rst)
        !(run && done));

    // Bus block must not restart a running multiply
    a_start_idle: assert property (@(posedge g_clk) disable iff (rst)
        start |-> !run);

endmodule

//--- logic/mdu_divider.sv
/*
 * Iterative restoring divider.
 * Divides operand magnitudes one quotient bit per cycle, then
 * applies the sign rules to give quotient or remainder.
 */

`timescale 1ns/1ps

module mdu_divider (
    input  logic                     g_clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     abort,
    input  mdu_pkg::mdu_op_e         op,
    input  logic                     op_word,
    input  logic [mdu_pkg::xlen-1:0] rs1,
    input  logic [mdu_pkg::xlen-1:0] rs2,
    output logic                     done,
    output logic [mdu_pkg::xlen-1:0] result
);

    import mdu_pkg::*;

    logic                 run;
    logic [div_ctr_w-1:0] ctr;        // Quotient bits left
    logic [xlen-1:0]      rem;        // Partial remainder
    logic [xlen-1:0]      quo;        // Dividend in, quotient out
    logic [xlen-1:0]      dsor;       // Divisor magnitude
    logic                 neg_q;
    logic                 neg_r;

    logic                 is_signed;
    logic                 is_rem;
    logic                 sign_a;
    logic                 sign_b;
    logic                 b_nz;
    logic [xlen-1:0]      a_ext;
    logic [xlen-1:0]      b_ext;
    logic [xlen-1:0]      a_mag;
    logic [xlen-1:0]      b_mag;
    logic [xlen:0]        rem_sh;
    logic [xlen:0]        diff;
    logic [xlen-1:0]      q_fix;
    logic [xlen-1:0]      r_fix;
    logic [xlen-1:0]      pick;

    assign is_signed = (op == op_div) || (op == op_rem);
    assign is_rem    = (op == op_rem) || (op == op_remu);

    // --------------------------------------------------
    // Operand magnitudes
    // --------------------------------------------------
    assign sign_a = is_signed && (op_word ? rs1[wlen-1] : rs1[xlen-1]);
    assign sign_b = is_signed && (op_word ? rs2[wlen-1] : rs2[xlen-1]);
    assign a_ext  = op_word ? {{wlen{sign_a}}, rs1[wlen-1:0]} : rs1;
    assign b_ext  = op_word ? {{wlen{sign_b}}, rs2[wlen-1:0]} : rs2;
    assign a_mag  = sign_a ? -a_ext : a_ext;
    assign b_mag  = sign_b ? -b_ext : b_ext;
    assign b_nz   = |b_ext;

    // Restoring step with the borrow in the top bit of diff
    assign rem_sh = {rem, quo[xlen-1]};
    assign diff   = rem_sh - {1'b0, dsor};

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (rst || abort) begin
            run  <= 1'b0;
            done <= 1'b0;
            ctr  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                run <= 1'b1;
                ctr <= op_word ? div_ctr_w'(wlen) : div_ctr_w'(xlen);
            end else if (run) begin
                if (ctr == 0) begin
                    run  <= 1'b0;
                    done <= 1'b1;
                end else begin
                    ctr <= ctr - 1'b1;
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge g_clk) begin
        if (start) begin
            rem   <= '0;
            // W dividend goes to the top so its bits shift out first
            quo   <= op_word ? {a_mag[wlen-1:0], {wlen{1'b0}}} : a_mag;
            dsor  <= op_word ? {{wlen{1'b0}}, b_mag[wlen-1:0]} : b_mag;
            neg_q <= (sign_a ^ sign_b) && b_nz;   // x/0 keeps all ones
            neg_r <= sign_a;
        end else if (run && ctr != 0) begin
            if (!diff[xlen]) begin
                rem <= diff[xlen-1:0];
                quo <= {quo[xlen-2:0], 1'b1};
            end else begin
                rem <= rem_sh[xlen-1:0];          // Restore
                quo <= {quo[xlen-2:0], 1'b0};
            end
        end
    end

    // --------------------------------------------------
    // Sign correction
    // --------------------------------------------------
    // Overflow case needs no special path since |min| / 1 is min
    assign q_fix  = neg_q ? -quo : quo;
    assign r_fix  = neg_r ? -rem : rem;
    assign pick   = is_rem ? r_fix : q_fix;
    assign result = op_word ? {{wlen{pick[wlen-1]}}, pick[wlen-1:0]} : pick;

    // Last step ends the run so the counter cannot wrap
    a_ctr_no_wrap: assert property (@(posedge g_clk) disable iff (rst)
        (run && ctr == 0) |=> !run);

endmodule

//--- logic/mdu_wb_regs.sv
/*
 * Wishbone classic register block for the multiply/divide unit.
 * Holds operands, control and result, starts the selected unit,
 * and tracks busy and done for the host.
 */

`timescale 1ns/1ps

module mdu_wb_regs (
    input  logic                     g_clk,
    input  logic                     rst,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [2:0]               wb_adr,
    input  logic [mdu_pkg::xlen-1:0] wb_dat_i,
    output logic [mdu_pkg::xlen-1:0] wb_dat_o,
    output logic                     wb_ack,
    output logic                     mul_start,
    output logic                     div_start,
    output logic                     abort,
    output mdu_pkg::mdu_op_e         op,
    output logic                     op_word,
    output logic [mdu_pkg::xlen-1:0] rs1,
    output logic [mdu_pkg::xlen-1:0] rs2,
    input  logic                     mul_done,
    input  logic                     div_done,
    input  logic [mdu_pkg::xlen-1:0] mul_result,
    input  logic [mdu_pkg::xlen-1:0] div_result
);

    import mdu_pkg::*;

    logic            req;          // New access, not yet acked
    logic            wr;
    logic            wr_ctrl;
    logic            ctrl_abort;
    mdu_op_e         new_op;
    logic            busy;
    logic            done_flag;
    logic [xlen-1:0] result_q;
    logic [xlen-1:0] ctrl_rd;
    logic [xlen-1:0] stat_rd;

    assign req        = wb_cyc && wb_stb && !wb_ack;
    assign wr         = req && wb_we;
    assign wr_ctrl    = wr && (wb_adr == addr_ctrl);
    assign ctrl_abort = wb_dat_i[ctrl_abort_bit];
    assign new_op     = mdu_op_e'(wb_dat_i[ctrl_op_lsb +: ctrl_op_w]);

    // --------------------------------------------------
    // Bus handshake, ack one cycle after request
    // --------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // Operands locked while a unit runs
    always_ff @(posedge g_clk) begin
        if (wr && !busy) begin
            if (wb_adr == addr_rs1) rs1 <= wb_dat_i;
            if (wb_adr == addr_rs2) rs2 <= wb_dat_i;
        end
    end

    // --------------------------------------------------
    // Start, abort and completion
    // --------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (rst) begin
            op        <= op_mul;
            op_word   <= 1'b0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
            abort     <= 1'b0;
            busy      <= 1'b0;
            done_flag <= 1'b0;
            result_q  <= '0;
        end else begin
            mul_start <= 1'b0;
            div_start <= 1'b0;
            abort     <= 1'b0;
            if (wr_ctrl && ctrl_abort) begin
                abort     <= 1'b1;         // Accepted even while busy
                busy      <= 1'b0;
                done_flag <= 1'b0;
            end else if (wr_ctrl && !busy) begin
                op        <= new_op;
                op_word   <= wb_dat_i[ctrl_word_bit];
                mul_start <= !new_op[2];
                div_start <= new_op[2];
                busy      <= 1'b1;
                done_flag <= 1'b0;
            end else if (busy && (mul_done || div_done)) begin
                result_q  <= mul_done ? mul_result : div_result;
                busy      <= 1'b0;
                done_flag <= 1'b1;
            end
        end
    end

    // Read mux
    always_comb begin
        ctrl_rd = '0;
        ctrl_rd[ctrl_op_lsb +: ctrl_op_w] = op;
        ctrl_rd[ctrl_word_bit] = op_word;
        stat_rd = '0;
        stat_rd[stat_busy_bit] = busy;
        stat_rd[stat_done_bit] = done_flag;
        case (wb_adr)
            addr_rs1:    wb_dat_o = rs1;
            addr_rs2:    wb_dat_o = rs2;
            addr_ctrl:   wb_dat_o = ctrl_rd;
            addr_result: wb_dat_o = result_q;
            addr_status: wb_dat_o = stat_rd;
            default:     wb_dat_o = '0;
        endcase
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    a_ack_in_cycle: assert property (@(posedge g_clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb));

    // Only the started unit may finish
    a_one_done: assert property (@(posedge g_clk) disable iff (rst)
        !(mul_done && div_done));

endmodule

//--- logic/mdu_top.sv
/*
 * Multiply/divide unit top level.
 * Wishbone register block driving the multiplier and divider.
 */

`timescale 1ns/1ps

module mdu_top (
    input  logic                     g_clk,
    input  logic                     rst,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [2:0]               wb_adr,
    input  logic [mdu_pkg::xlen-1:0] wb_dat_i,
    output logic [mdu_pkg::xlen-1:0] wb_dat_o,
    output logic                     wb_ack
);

    import mdu_pkg::*;

    logic            mul_start;
    logic            div_start;
    logic            abort;
    mdu_op_e         op;
    logic            op_word;
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
    logic            mul_done;
    logic            div_done;
    logic [xlen-1:0] mul_result;
    logic [xlen-1:0] div_result;

    mdu_wb_regs u_regs (
        .g_clk      (g_clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack     (wb_ack),
        .mul_start  (mul_start),
        .div_start  (div_start),
        .abort      (abort),
        .op         (op),
        .op_word    (op_word),
        .rs1        (rs1),
        .rs2        (rs2),
        .mul_done   (mul_done),
        .div_done   (div_done),
        .mul_result (mul_result),
        .div_result (div_result)
    );

    mdu_multiplier u_mul (
        .g_clk   (g_clk),
        .rst     (rst),
        .start   (mul_start),
        .abort   (abort),
        .op      (op),
        .op_word (op_word),
        .rs1     (rs1),
        .rs2     (rs2),
        .done    (mul_done),
        .result  (mul_result)
    );

    mdu_divider u_div (
        .g_clk   (g_clk),
        .rst     (rst),
        .start   (div_start),
        .abort   (abort),
        .op      (op),
        .op_word (op_word),
        .rs1     (rs1),
        .rs2     (rs2),
        .done    (div_done),
        .result  (div_result)
    );

endmodule

//--- verif/mdu_tb.sv
/*
 * Testbench for the multiply/divide unit.
 * Runs vectors from a hex file over the Wishbone bus and checks
 * results, status, register readback, busy lockout and abort.
 */

`timescale 1ns/1ps

module mdu_tb;

    import mdu_pkg::*;

    localparam int clk_half     = 50;     // 100 ns period
    localparam int rand_seed    = 17;
    localparam int ack_timeout  = 10;     // Cycles per bus access
    localparam int poll_timeout = 200;    // Status polls per operation
    localparam int max_vectors  = 64;

    logic            g_clk;
    logic            rst;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    logic [2:0]      wb_adr;
    logic [xlen-1:0] wb_dat_i;
    logic [xlen-1:0] wb_dat_o;
    logic            wb_ack;

    logic [xlen-1:0] vec_mem [0:4*max_vectors-1];   // ctrl, rs1, rs2, expected
    int              num_vecs;

    mdu_top UUT (
        .g_clk    (g_clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack)
    );

    always #(clk_half) g_clk = ~g_clk;

    // --------------------------------------------------
    // Reporting
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected 0x%016h actual 0x%016h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "Stopping on mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        $display("Verification failed");
        $fatal(1, "Stopping on timeout");
    endtask

    // --------------------------------------------------
    // Bus access
    // --------------------------------------------------
    task automatic idle_gap();
        int n;
        n = $urandom_range(3, 0);
        repeat (n) @(posedge g_clk);
    endtask

    task automatic wait_ack(input string what);
        int waited;
        waited = 0;
        while (!wb_ack) begin
            if (waited == ack_timeout) report_timeout(what);
            @(posedge g_clk);
            #1;
            waited++;
        end
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [xlen-1:0] data);
        idle_gap();
        @(posedge g_clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_i = data;
        wait_ack("no wb_ack on write");
        // Hold the request until the edge that samples ack
        @(posedge g_clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [xlen-1:0] data);
        idle_gap();
        @(posedge g_clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack("no wb_ack on read");
        data   = wb_dat_o;      // Valid while ack is high
        @(posedge g_clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // --------------------------------------------------
    // Operation sequences
    // --------------------------------------------------
    task automatic start_vector(input int idx);
        wb_write(addr_rs1, vec_mem[4*idx+1]);
        wb_write(addr_rs2, vec_mem[4*idx+2]);
        wb_write(addr_ctrl, vec_mem[4*idx]);
    endtask

    // Busy on the first poll and later done with busy clear
    task automatic wait_done();
        logic [xlen-1:0] stat;
        int              polls;
        polls = 0;
        wb_read(addr_status, stat);
        check_value("status (first poll)", xlen'(1) << stat_busy_bit, stat);
        while (!stat[stat_done_bit]) begin
            if (polls == poll_timeout) report_timeout("status done bit never set");
            wb_read(addr_status, stat);
            polls++;
        end
        check_value("status (done)", xlen'(1) << stat_done_bit, stat);
    endtask

    task automatic finish_vector(input int idx);
        logic [xlen-1:0] res;
        wait_done();
        wb_read(addr_result, res);
        check_value($sformatf("result of vector %0d", idx), vec_mem[4*idx+3], res);
    endtask

    task automatic run_vector(input int idx);
        start_vector(idx);
        finish_vector(idx);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        logic [xlen-1:0] rd;
        logic [xlen-1:0] ctrl_mask;
        int              last;

        g_clk      = 1'b0;
        rst        = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_i   = '0;
        void'($urandom(rand_seed));

        $readmemh("verif/mdu_vectors.hex", vec_mem);
        num_vecs = 0;
        while (num_vecs < max_vectors && !$isunknown(vec_mem[4*num_vecs])) begin
            num_vecs++;
        end
        if (num_vecs < 2) begin
            $display("Vector file is missing or holds fewer than two vectors");
            $display("Verification failed");
            $fatal(1, "Stopping on bad stimulus");
        end

        repeat (3) @(posedge g_clk);
        #1;
        rst = 1'b0;

        // Idle state after reset
        wb_read(addr_status, rd);
        check_value("status after reset", '0, rd);
        wb_read(addr_result, rd);
        check_value("result after reset", '0, rd);

        for (int i = 0; i < num_vecs; i++) begin
            run_vector(i);
        end

        // Registers of the last vector read back
        last      = num_vecs - 1;
        ctrl_mask = (xlen'(4'hf) << ctrl_op_lsb) | (xlen'(1) << ctrl_word_bit);
        wb_read(addr_rs1, rd);
        check_value("rs1 readback", vec_mem[4*last+1], rd);
        wb_read(addr_rs2, rd);
        check_value("rs2 readback", vec_mem[4*last+2], rd);
        wb_read(addr_ctrl, rd);
        check_value("ctrl readback", vec_mem[4*last] & ctrl_mask, rd);

        // Second control write lands while busy
        start_vector(0);
        wb_write(addr_ctrl, vec_mem[4]);
        finish_vector(0);

        // Abort mid-operation and then a clean run
        start_vector(0);
        wb_write(addr_ctrl, xlen'(1) << ctrl_abort_bit);
        wb_read(addr_status, rd);
        check_value("status after abort", '0, rd);
        run_vector(1);

        $display("Verification passed");
        $finish;
    end

endmodule

//--- verif/mdu_vectors.hex
// Columns: ctrl rs1 rs2 expected, one vector per line, 64-bit hex
// ctrl bits 3:0 opcode (0 mul .. 7 remu), bit 4 word form
04 FFFFFFFFFFFFFF9C 0000000000000007 FFFFFFFFFFFFFFF2
00 0000000012345678 0000000000001000 0000012345678000
00 FFFFFFFFFFFFFFFD 0000000000000005 FFFFFFFFFFFFFFF1
01 FFFFFFFFFFFFFFFD 0000000000000005 FFFFFFFFFFFFFFFF
01 4000000000000000 4000000000000000 1000000000000000
01 8000000000000000 8000000000000000 4000000000000000
02 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
02 0000000000000002 8000000000000000 0000000000000001
03 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFE
05 FFFFFFFFFFFFFFFF 0000000000000003 5555555555555555
06 FFFFFFFFFFFFFF9C 0000000000000007 FFFFFFFFFFFFFFFE
07 00000000000003E8 0000000000000021 000000000000000A
04 00000000000004D2 0000000000000000 FFFFFFFFFFFFFFFF
06 FFFFFFFFFFFFFFFB 0000000000000000 FFFFFFFFFFFFFFFB
04 8000000000000000 FFFFFFFFFFFFFFFF 8000000000000000
06 8000000000000000 FFFFFFFFFFFFFFFF 0000000000000000
10 0000000040000000 0000000000000002 FFFFFFFF80000000
11 12345678FFFFFFF9 0000000000000006 FFFFFFFFFFFFFFD6
12 00000000FFFFFFFE 0000000000000003 FFFFFFFFFFFFFFFA
13 00000000FFFFFFFF 00000000FFFFFFFF 0000000000000001
14 00000000FFFFFF9C 0000000000000007 FFFFFFFFFFFFFFF2
15 AAAAAAAAFFFFFFFF 0000000000000002 000000007FFFFFFF
16 0000000000000064 00000000FFFFFFF9 0000000000000002
17 00000000FFFFFFFF 0000000000000010 000000000000000F
14 0000000080000000 00000000FFFFFFFF FFFFFFFF80000000
15 0000000012345678 0000000000000000 FFFFFFFFFFFFFFFF
16 0000000080000001 0000000000000000 FFFFFFFF80000001

//--- flist.f
logic/mdu_pkg.sv
logic/mdu_multiplier.sv
logic/mdu_divider.sv
logic/mdu_wb_regs.sv
logic/mdu_top.sv
verif/mdu_tb.sv
